//--- sim.f
+incdir+tests
rtl/rv_pkg.sv
rtl/ctrl_if.sv
rtl/main_fsm.sv
rtl/instr_decode.sv
rtl/alu_execute.sv
rtl/result_writeback.sv
rtl/rv_core_top.sv
tests/tb_clock_gen.sv
tests/tb_rv_core.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sim.f --top-module tb_rv_core \
        --Mdir obj_dir -o tb_rv_core_sim; then
    echo "verilator build failed"
    exit 1
fi

if ! sim_out=$(./obj_dir/tb_rv_core_sim 2>&1); then
    printf '%s\n' "$sim_out"
    echo "simulation exited with an error status"
    exit 1
fi
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- tests/tb_ref_model.svh
`ifndef tb_ref_model_svh
`define tb_ref_model_svh

// architectural state of the core as the RV32I rules define it
word_t model_regs [32];
word_t model_pc;
word_t data_mem [256];  // words at 0x400 .. 0x7fc

function int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % 32'(n));
endfunction

function reg_idx_t pick_reg();
    // low registers half the time so operands collide more often
    if (rand_below(2) == 0) begin
        return 5'(rand_below(4));
    end
    return 5'(rand_below(32));
endfunction

function word_t fill_word(input word_t addr);
    return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]};
endfunction

function void reset_model();
    for (int i = 0; i < 32; i++) begin
        model_regs[i[4:0]] = '0;
    end
    for (int i = 0; i < 256; i++) begin
        data_mem[i[7:0]] = fill_word(32'h0000_0400 | {22'd0, i[7:0], 2'b00});
    end
    model_pc = reset_vector;
endfunction

function void set_reg(input reg_idx_t rd, input word_t v);
    if (rd != 5'd0) begin
        model_regs[rd] = v;  // x0 stays zero
    end
endfunction

// integer ops by funct3, alt is instruction bit 30
function word_t alu_ref(input logic [2:0] f3, input logic alt, input word_t a, input word_t b);
    word_t r;
    case (f3)
        3'd0: r = alt ? (a - b) : (a + b);
        3'd1: r = a << b[4:0];
        3'd2: r = {31'd0, $signed(a) < $signed(b)};
        3'd3: r = {31'd0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
            if (alt) begin
                r = $signed(a) >>> b[4:0];
            end else begin
                r = a >> b[4:0];
            end
        end
        3'd6: r = a | b;
        default: r = a & b;
    endcase
    return r;
endfunction

function logic branch_ref(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
        3'd0: return a == b;                    // beq
        3'd1: return a != b;                    // bne
        3'd4: return $signed(a) < $signed(b);   // blt
        3'd5: return $signed(a) >= $signed(b);  // bge
        3'd6: return a < b;                     // bltu
        default: return a >= b;                 // bgeu
    endcase
endfunction

// makes one legal instruction for the fetch at model_pc and executes it
task automatic step_model(output word_t instr, output logic is_load, output logic is_store,
                          output word_t d_addr, output word_t d_data);
    int         kind;
    reg_idx_t   rd;
    reg_idx_t   rs1;
    reg_idx_t   rs2;
    logic [2:0] f3;
    logic       alt;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [7:0] idx;
    word_t      a;
    word_t      b;
    word_t      off;
    word_t      pc_now;

    pc_now   = model_pc;
    model_pc = pc_now + 32'd4;
    is_load  = 1'b0;
    is_store = 1'b0;
    d_addr   = '0;
    d_data   = '0;
    rd       = pick_reg();
    rs1      = pick_reg();
    rs2      = pick_reg();
    a        = model_regs[rs1];
    b        = model_regs[rs2];
    imm20    = 20'($random(seed));
    imm12    = 12'($random(seed));
    kind     = rand_below(10);
    case (kind)
        0: begin  // lui
            instr = {imm20, rd, 7'b011_0111};
            set_reg(rd, {imm20, 12'h000});
        end
        1: begin  // auipc
            instr = {imm20, rd, 7'b001_0111};
            set_reg(rd, pc_now + {imm20, 12'h000});
        end
        2, 3: begin
            f3 = 3'(rand_below(8));
            if (f3 == 3'd1) begin
                imm12 = {7'd0, imm12[4:0]};
            end else if (f3 == 3'd5) begin
                imm12 = {1'b0, imm12[10], 5'd0, imm12[4:0]};  // srli or srai
            end
            alt   = (f3 == 3'd5) && imm12[10];
            instr = {imm12, rs1, f3, rd, 7'b001_0011};
            set_reg(rd, alu_ref(f3, alt, a, {{20{imm12[11]}}, imm12}));
        end
        4, 5: begin
            f3    = 3'(rand_below(8));
            alt   = (f3 == 3'd0 || f3 == 3'd5) ? (rand_below(2) == 1) : 1'b0;
            instr = {1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b011_0011};
            set_reg(rd, alu_ref(f3, alt, a, b));
        end
        6: begin  // lw off x0
            idx      = 8'(rand_below(256));
            d_addr   = 32'h0000_0400 | {22'd0, idx, 2'b00};
            d_data   = data_mem[idx];
            is_load  = 1'b1;
            instr    = {d_addr[11:0], 5'd0, 3'b010, rd, 7'b000_0011};
            set_reg(rd, d_data);
        end
        7: begin  // sw off x0
            idx      = 8'(rand_below(256));
            d_addr   = 32'h0000_0400 | {22'd0, idx, 2'b00};
            d_data   = b;
            is_store = 1'b1;
            imm12    = d_addr[11:0];
            instr    = {imm12[11:5], rs2, 5'd0, 3'b010, imm12[4:0], 7'b010_0011};
            data_mem[idx] = b;
        end
        8: begin
            f3 = 3'(rand_below(6));
            if (f3 >= 3'd2) begin
                f3 = f3 + 3'd2;  // skip the two reserved codes
            end
            off   = word_t'(4 * (rand_below(15) - 7));
            instr = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b110_0011};
            if (branch_ref(f3, a, b)) begin
                model_pc = pc_now + off;
            end
        end
        default: begin  // jal
            off   = word_t'(4 * (rand_below(31) - 15));
            instr = {off[20], off[10:1], off[11], off[19:12], rd, 7'b110_1111};
            set_reg(rd, pc_now + 32'd4);
            model_pc = pc_now + off;
        end
    endcase
endtask

`endif

//--- tests/tb_rv_core.sv
`timescale 1ns/1ns

module tb_rv_core import rv_pkg::*; ();

    logic   clk;
    logic   arst_n;
    logic   mem_valid;
    logic   mem_write;
    word_t  mem_addr;
    word_t  mem_wdata;
    logic   mem_ready;
    word_t  mem_rdata;
    integer seed;

    `include "tb_ref_model.svh"

    tb_clock_gen clk_gen_i (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rv_core_top dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_valid (mem_valid),
        .mem_write (mem_write),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    task automatic fail_now();
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, got, exp);
            fail_now();
        end
    endtask

    // request must match the model and hold while mem_ready is low
    task automatic compare_request(input logic exp_write, input word_t exp_addr,
                                   input word_t exp_wdata);
        check_bit("mem_valid", mem_valid, 1'b1);
        check_bit("mem_write", mem_write, exp_write);
        check_word("mem_addr", mem_addr, exp_addr);
        if (exp_write) begin
            check_word("mem_wdata", mem_wdata, exp_wdata);
        end
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        while (arst_n !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                $display("reset was never released");
                fail_now();
            end
        end
    endtask

    // memory responder for one access, ends one edge after completion
    task automatic serve_access(input logic exp_write, input word_t exp_addr,
                                input word_t exp_wdata, input word_t rdata, input int num);
        int cycles;
        int delay;
        cycles = 0;
        while (mem_valid !== 1'b1) begin
            @(posedge clk);
            cycles++;
            if (cycles > 16) begin
                $display("timed out waiting for mem_valid of access in instruction %0d", num);
                fail_now();
            end
        end
        delay = rand_below(4);
        compare_request(exp_write, exp_addr, exp_wdata);
        repeat (delay) begin
            @(posedge clk);
            compare_request(exp_write, exp_addr, exp_wdata);
        end
        mem_ready <= 1'b1;
        mem_rdata <= rdata;
        @(posedge clk);
        compare_request(exp_write, exp_addr, exp_wdata);  // completing edge
        mem_ready <= 1'b0;
        mem_rdata <= word_t'($random(seed));  // junk while idle
        @(posedge clk);
        if (!exp_write) begin
            check_bit("mem_valid", mem_valid, 1'b0);  // decode or load writeback follows
        end
    endtask

    initial begin
        word_t instr;
        word_t fetch_addr;
        word_t d_addr;
        word_t d_data;
        logic  is_load;
        logic  is_store;

        seed = 32'h4a6a_8b82;
        mem_ready <= 1'b0;
        mem_rdata <= '0;
        reset_model();
        wait_reset();
        for (int n = 0; n < 2000; n++) begin
            fetch_addr = model_pc;
            step_model(instr, is_load, is_store, d_addr, d_data);
            serve_access(1'b0, fetch_addr, '0, instr, n);
            if (is_load) begin
                serve_access(1'b0, d_addr, '0, d_data, n);
            end else if (is_store) begin
                serve_access(1'b1, d_addr, d_data, word_t'($random(seed)), n);
            end
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        arst_n <= 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

//--- rtl/rv_core_top.sv
`timescale 1ns/1ns

module rv_core_top import rv_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    output logic  mem_valid,
    output logic  mem_write,
    output word_t mem_addr,
    output word_t mem_wdata,
    input  logic  mem_ready,
    input  word_t mem_rdata
);

    ctrl_if ctrl_i ();

    opcode_e    op;
    reg_idx_t   rs1, rs2, rd;
    logic [2:0] funct3;
    logic       funct7b5;
    word_t      imm_ext;
    word_t      alu_result, alu_out, rd2_buf;
    logic       taken;
    word_t      pc, old_pc, result;

    main_fsm u_fsm (
        .clk, .arst_n, .op, .mem_ready, .mem_valid, .ctrl(ctrl_i)
    );

    instr_decode u_decode (
        .clk, .arst_n, .ir_write(ctrl_i.ir_write), .mem_rdata,
        .op, .rs1, .rs2, .rd, .funct3, .funct7b5, .imm_ext
    );

    alu_execute u_execute (
        .clk, .arst_n, .ctrl(ctrl_i), .rs1, .rs2, .rd, .funct3, .funct7b5, .imm_ext,
        .pc, .old_pc, .result, .alu_result, .alu_out, .rd2_buf, .taken
    );

    result_writeback u_result (
        .clk, .arst_n, .ctrl(ctrl_i), .mem_valid, .mem_ready, .mem_rdata,
        .alu_result, .alu_out, .taken, .pc, .old_pc, .result, .mem_addr
    );

    assign mem_write = ctrl_i.mem_write;
    assign mem_wdata = rd2_buf;  // store data straight from the rs2 buffer

endmodule

//--- rtl/result_writeback.sv
`timescale 1ns/1ns

module result_writeback import rv_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    ctrl_if.result ctrl,
    input  logic  mem_valid,
    input  logic  mem_ready,
    input  word_t mem_rdata,
    input  word_t alu_result,
    input  word_t alu_out,
    input  logic  taken,
    output word_t pc,
    output word_t old_pc,
    output word_t result,
    output word_t mem_addr
);

    word_t data_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_vector;
        end else if (ctrl.pc_update || (ctrl.branch && taken)) begin
            pc <= result;  // next pc always comes through result
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_write) begin
            old_pc <= pc;  // address of the instruction just fetched
        end
        if (mem_valid && mem_ready && ctrl.adr_src == adr_result) begin
            data_q <= mem_rdata;  // data phase done
        end
    end

    always_comb begin
        case (ctrl.result_src)
            res_alu_out: result = alu_out;
            res_data:    result = data_q;
            default:     result = alu_result;
        endcase
    end

    assign mem_addr = (ctrl.adr_src == adr_result) ? result : pc;

    addr_stable_a: assert property (@(posedge clk) disable iff (!arst_n)
        mem_valid && !mem_ready |=> $stable(mem_addr));

endmodule

//--- rtl/alu_execute.sv
`timescale 1ns/1ns

module alu_execute import rv_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    ctrl_if.exec       ctrl,
    input  reg_idx_t   rs1,
    input  reg_idx_t   rs2,
    input  reg_idx_t   rd,
    input  logic [2:0] funct3,
    input  logic       funct7b5,
    input  word_t      imm_ext,
    input  word_t      pc,
    input  word_t      old_pc,
    input  word_t      result,
    output word_t      alu_result,
    output word_t      alu_out,
    output word_t      rd2_buf,
    output logic       taken
);

    word_t regs [32];
    word_t rd1_buf;
    word_t src_a, src_b;
    logic  is_sub;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write && rd != '0) begin  // x0 never written
            regs[rd] <= result;
        end
    end

    always_ff @(posedge clk) begin
        rd1_buf <= regs[rs1];
        rd2_buf <= regs[rs2];
        alu_out <= alu_result;
    end

    always_comb begin
        case (ctrl.alu_src_a)
            src_a_old_pc:  src_a = old_pc;
            src_a_rd1_buf: src_a = rd1_buf;
            default:       src_a = pc;
        endcase
        case (ctrl.alu_src_b)
            src_b_imm_ext: src_b = imm_ext;
            src_b_const_4: src_b = 32'd4;
            default:       src_b = rd2_buf;
        endcase
    end

    // only a register operand makes bit 30 mean sub, addi keeps it as imm
    assign is_sub = funct7b5 && (ctrl.alu_src_b == src_b_rd2_buf);

    always_comb begin
        case (ctrl.alu_op)
            alu_arith_logic: begin
                case (funct3)
                    3'b000:  alu_result = is_sub ? src_a - src_b : src_a + src_b;
                    3'b001:  alu_result = src_a << src_b[4:0];
                    3'b010:  alu_result = word_t'($signed(src_a) < $signed(src_b));
                    3'b011:  alu_result = word_t'(src_a < src_b);
                    3'b100:  alu_result = src_a ^ src_b;
                    3'b101:  alu_result = funct7b5 ? word_t'($signed(src_a) >>> src_b[4:0])
                                                   : src_a >> src_b[4:0];
                    3'b110:  alu_result = src_a | src_b;
                    default: alu_result = src_a & src_b;
                endcase
            end
            alu_branch: alu_result = src_a - src_b;
            alu_lui:    alu_result = src_b;  // imm already shifted up
            default:    alu_result = src_a + src_b;  // add, auipc
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  taken = (src_a == src_b);
            3'b001:  taken = (src_a != src_b);
            3'b100:  taken = ($signed(src_a) < $signed(src_b));
            3'b101:  taken = ($signed(src_a) >= $signed(src_b));
            3'b110:  taken = (src_a < src_b);
            3'b111:  taken = (src_a >= src_b);
            default: taken = 1'b0;
        endcase
        taken = taken && (ctrl.alu_op == alu_branch);
    end

    x0_zero_a: assert property (@(posedge clk) disable iff (!arst_n)
        ctrl.reg_write && rd == '0 |=> regs[0] == '0);

endmodule

//--- rtl/instr_decode.sv
`timescale 1ns/1ns

module instr_decode import rv_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       ir_write,
    input  word_t      mem_rdata,
    output opcode_e    op,
    output reg_idx_t   rs1,
    output reg_idx_t   rs2,
    output reg_idx_t   rd,
    output logic [2:0] funct3,
    output logic       funct7b5,
    output word_t      imm_ext
);

    instr_u ir;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ir <= '0;
        end else if (ir_write) begin
            ir <= mem_rdata;
        end
    end

    assign op       = opcode_e'(ir.r.opcode);
    assign rs1      = ir.r.rs1;
    assign rs2      = ir.r.rs2;
    assign rd       = ir.r.rd;
    assign funct3   = ir.r.funct3;
    assign funct7b5 = ir.r.funct7[5];  // sub / sra select

    always_comb begin
        case (op)
            op_itype, op_load: imm_ext = {{20{ir.i.imm[11]}}, ir.i.imm};
            op_store:          imm_ext = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
            op_branch: imm_ext = {{19{ir.b.imm12}}, ir.b.imm12, ir.b.imm11,
                                  ir.b.imm10_5, ir.b.imm4_1, 1'b0};
            op_lui, op_auipc:  imm_ext = {ir.u.imm, 12'h000};
            op_jal:    imm_ext = {{11{ir.j.imm20}}, ir.j.imm20, ir.j.imm19_12,
                                  ir.j.imm11, ir.j.imm10_1, 1'b0};
            default:           imm_ext = '0;  // rtype has no immediate
        endcase
    end

    // every fetch is followed by a decode cycle
    single_load_a: assert property (@(posedge clk) disable iff (!arst_n)
        ir_write |=> !ir_write);

endmodule

//--- rtl/main_fsm.sv
`timescale 1ns/1ns

module main_fsm import rv_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,
    input  opcode_e op,
    input  logic    mem_ready,
    output logic    mem_valid,
    ctrl_if.fsm     ctrl
);

    typedef enum logic [3:0] {
        s_fetch, s_decode, s_mem_addr, s_mem_read, s_mem_wb, s_mem_write, s_exec_r,
        s_alu_wb, s_exec_i, s_jal, s_branch, s_lui, s_auipc
    } state_e;

    state_e state, next_state;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= s_fetch;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = s_fetch;
        case (state)
            s_fetch:     next_state = mem_ready ? s_decode : s_fetch;
            s_decode: begin
                case (op)
                    op_load, op_store: next_state = s_mem_addr;
                    op_rtype:          next_state = s_exec_r;
                    op_itype:          next_state = s_exec_i;
                    op_jal:            next_state = s_jal;
                    op_branch:         next_state = s_branch;
                    op_lui:            next_state = s_lui;
                    op_auipc:          next_state = s_auipc;
                    default:           next_state = s_fetch;  // unknown opcode
                endcase
            end
            s_mem_addr:  next_state = (op == op_load) ? s_mem_read : s_mem_write;
            s_mem_read:  next_state = mem_ready ? s_mem_wb : s_mem_read;
            s_mem_write: next_state = mem_ready ? s_fetch : s_mem_write;
            s_exec_r, s_exec_i, s_jal, s_lui, s_auipc: next_state = s_alu_wb;
            default:     next_state = s_fetch;  // mem_wb, alu_wb, branch
        endcase
    end

    always_comb begin
        mem_valid       = 1'b0;
        ctrl.adr_src    = adr_pc;
        ctrl.ir_write   = 1'b0;
        ctrl.alu_src_a  = src_a_pc;
        ctrl.alu_src_b  = src_b_rd2_buf;
        ctrl.alu_op     = alu_add;
        ctrl.result_src = res_alu_result;
        ctrl.pc_update  = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.reg_write  = 1'b0;
        ctrl.mem_write  = 1'b0;
        case (state)
            s_fetch: begin
                // pc + 4 straight into pc once the word arrives
                mem_valid       = 1'b1;
                ctrl.alu_src_b  = src_b_const_4;
                ctrl.ir_write   = mem_ready;
                ctrl.pc_update  = mem_ready;
            end
            s_decode: begin
                ctrl.alu_src_a  = src_a_old_pc;  // branch/jal target into alu_out
                ctrl.alu_src_b  = src_b_imm_ext;
            end
            s_mem_addr, s_mem_read, s_mem_write: begin
                // same sum every cycle so alu_out holds the address
                ctrl.alu_src_a  = src_a_rd1_buf;
                ctrl.alu_src_b  = src_b_imm_ext;
                if (state != s_mem_addr) begin
                    mem_valid       = 1'b1;
                    ctrl.adr_src    = adr_result;
                    ctrl.result_src = res_alu_out;
                    ctrl.mem_write  = (state == s_mem_write);
                end
            end
            s_mem_wb: begin
                ctrl.result_src = res_data;
                ctrl.reg_write  = 1'b1;
            end
            s_exec_r, s_exec_i: begin
                ctrl.alu_src_a  = src_a_rd1_buf;
                ctrl.alu_src_b  = (state == s_exec_r) ? src_b_rd2_buf : src_b_imm_ext;
                ctrl.alu_op     = alu_arith_logic;
            end
            s_alu_wb: begin
                ctrl.result_src = res_alu_out;
                ctrl.reg_write  = 1'b1;
            end
            s_jal: begin
                // target from decode goes to pc, link value lands in alu_out
                ctrl.alu_src_a  = src_a_old_pc;
                ctrl.alu_src_b  = src_b_const_4;
                ctrl.result_src = res_alu_out;
                ctrl.pc_update  = 1'b1;
            end
            s_branch: begin
                ctrl.alu_src_a  = src_a_rd1_buf;
                ctrl.alu_op     = alu_branch;
                ctrl.result_src = res_alu_out;
                ctrl.branch     = 1'b1;
            end
            s_lui: begin
                ctrl.alu_src_b  = src_b_imm_ext;
                ctrl.alu_op     = alu_lui;
            end
            s_auipc: begin
                ctrl.alu_src_a  = src_a_old_pc;
                ctrl.alu_src_b  = src_b_imm_ext;
                ctrl.alu_op     = alu_auipc;
            end
            default: ;
        endcase
    end

    state_legal_a: assert property (@(posedge clk) disable iff (!arst_n) state <= s_auipc);

    // a store is only ever presented as a valid memory request
    write_needs_valid_a: assert property (@(posedge clk) disable iff (!arst_n)
        ctrl.mem_write |-> mem_valid);

endmodule

//--- rtl/ctrl_if.sv
`timescale 1ns/1ns

interface ctrl_if import rv_pkg::*; ();
    adr_src_e    adr_src;
    logic        ir_write;
    src_a_e      alu_src_a;
    src_b_e      alu_src_b;
    alu_op_e     alu_op;
    result_src_e result_src;
    logic        pc_update;
    logic        branch;   // pc loads only if taken
    logic        reg_write;
    logic        mem_write;

    modport fsm (
        output adr_src, ir_write, alu_src_a, alu_src_b, alu_op,
        output result_src, pc_update, branch, reg_write, mem_write
    );

    modport exec (input alu_src_a, alu_src_b, alu_op, reg_write);

    modport result (input adr_src, result_src, pc_update, branch, ir_write);
endinterface

//--- rtl/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    localparam word_t reset_vector = 32'h0000_0000;

    typedef enum logic [6:0] {
        op_load   = 7'b000_0011,
        op_store  = 7'b010_0011,
        op_rtype  = 7'b011_0011,
        op_itype  = 7'b001_0011,
        op_jal    = 7'b110_1111,
        op_branch = 7'b110_0011,
        op_lui    = 7'b011_0111,
        op_auipc  = 7'b001_0111
    } opcode_e;

    typedef enum logic [2:0] {alu_add, alu_arith_logic, alu_branch, alu_lui, alu_auipc} alu_op_e;
    typedef enum logic [1:0] {src_a_pc, src_a_old_pc, src_a_rd1_buf} src_a_e;
    typedef enum logic [1:0] {src_b_rd2_buf, src_b_imm_ext, src_b_const_4} src_b_e;
    typedef enum logic [1:0] {res_alu_result, res_alu_out, res_data} result_src_e;
    typedef enum logic {adr_pc, adr_result} adr_src_e;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

endpackage
